// File: nobl_pkg.sv
// Widths are fixed by one 18-bit, 512K-word ZBT/NoBL part and change only with the part.
package nobl_pkg;

	// The part stores 18-bit words.
	// This is the width of the user data as well, since the FIFO does not pack
	// or split words on their way to the RAM.
	localparam int DATA_W = 18;

	// The part has 512K words, so the word address is 19 bits wide.
	// A FIFO built on it may use fewer address bits than this.
	// The unused upper bits are then driven as zero.
	localparam int ADDR_W = 19;

	// One FIFO word.
	// The same type is used on the user ports and on both halves of the RAM
	// data bus, which the FPGA pads split into an input and an output.
	typedef logic [DATA_W-1:0] word_t;

	// One RAM word address as it appears on the address pins.
	typedef logic [ADDR_W-1:0] ram_addr_t;

	// One RAM operation in one clock cycle.
	// The controller produces one of these every cycle, and the SRAM interface
	// turns it into pin activity.
	// When en is low the other fields carry no meaning.
	// The interface still registers addr and wdata every cycle, so they need
	// not be held at zero between operations.
	typedef struct packed {
		// An operation is requested in this cycle.
		logic      en;
		// The operation is a write.
		// It is a read when this is low.
		logic      we;
		// RAM word address of the operation.
		ram_addr_t addr;
		// Data to store.
		// Only meaningful for a write.
		word_t     wdata;
	} ram_req_t;

	// The widths below follow from the fields above.
	// They are kept here so that a change to a field is caught in one place
	// by anyone who packs or unpacks the request by hand in a waveform viewer.
	// The whole request is 1 + 1 + ADDR_W + DATA_W bits, so 39 bits for this part.
	localparam int REQ_W = $bits(ram_req_t);

	// A request with no operation.
	// Handy as a default for anything that drives a ram_req_t from reset.
	localparam ram_req_t REQ_IDLE = '{en: 1'b0, we: 1'b0, addr: '0, wdata: '0};

endpackage

// File: nobl_fifo_ctrl.sv
// Serves a write before a colliding read and holds off writes for one cycle; no read room check.
`timescale 1ns/1ns

module nobl_fifo_ctrl
	import nobl_pkg::*;
#(
	parameter int FIFO_DEPTH = 19
)
(
	input  logic     clk,
	input  logic     rst,
	input  word_t    write_data,
	input  logic     write_strobe,
	input  logic     read_strobe,
	output logic     space_avail,
	output ram_req_t req
);

	// The FIFO holds half of what the pointers can address.
	// Capacity then fits in FIFO_DEPTH bits with its top value one bit set.
	localparam logic [FIFO_DEPTH-1:0] FIFO_WORDS = FIFO_DEPTH'(1) << (FIFO_DEPTH - 1);

	// Capacity when exactly one word is stored.
	localparam logic [FIFO_DEPTH-1:0] ONE_WORD = FIFO_WORDS - FIFO_DEPTH'(1);

	// Pointers wrap at the full pointer range.
	logic [FIFO_DEPTH-1:0] wr_ptr;
	logic [FIFO_DEPTH-1:0] rd_ptr;

	// Free slots.
	// Starts at FIFO_WORDS and counts down on every write.
	logic [FIFO_DEPTH-1:0] capacity;

	// Registered not-empty flag with a one cycle lookahead.
	logic not_empty;

	// A read that was accepted together with a write and is issued one cycle later.
	logic rd_pend;

	logic wr_acc;
	logic rd_acc;
	logic rd_issue;
	logic [FIFO_DEPTH-1:0] ptr_sel;

	// A write is taken whenever the flag shown to the user says there is room.
	assign wr_acc = write_strobe && space_avail;

	// No new read is taken in the cycle that serves a pending one.
	// The RAM has a single port, so that cycle belongs to the pending read.
	assign rd_acc = read_strobe && not_empty && !rd_pend;

	// A read reaches the RAM either from the pending register or directly when
	// no write competes for the port.
	assign rd_issue = rd_pend || (rd_acc && !wr_acc);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			capacity    <= FIFO_WORDS;
			space_avail <= 1'b0;
			not_empty   <= 1'b0;
			rd_pend     <= 1'b0;
		end
		else
		begin
			// Room is withdrawn when the FIFO is full, when this write takes the
			// last slot, and for one cycle after a collision.
			// The collision case gives the deferred read a free cycle on the RAM.
			space_avail <= !((capacity == '0) || (wr_acc && rd_acc) ||
				((capacity == FIFO_DEPTH'(1)) && wr_acc));

			// Capacity lags the RAM by one cycle.
			// A read of the last word must therefore clear the flag at once.
			// A write into an empty FIFO shows up one cycle late, which is safe.
			not_empty <= !((capacity == FIFO_WORDS) ||
				((capacity == ONE_WORD) && rd_issue));

			rd_pend  <= rd_acc && wr_acc;
			wr_ptr   <= wr_ptr + FIFO_DEPTH'(wr_acc);
			rd_ptr   <= rd_ptr + FIFO_DEPTH'(rd_issue);
			capacity <= capacity - FIFO_DEPTH'(wr_acc) + FIFO_DEPTH'(rd_issue);
		end
	end

	// The write owns the port in a collision cycle.
	assign ptr_sel = wr_acc ? wr_ptr : rd_ptr;

	// The RAM is driven directly from this request.
	// The SRAM interface does all of the pin registering.
	always_comb
	begin
		req       = REQ_IDLE;
		req.en    = wr_acc || rd_issue;
		req.we    = wr_acc;
		req.addr  = ADDR_W'(ptr_sel);
		req.wdata = write_data;
	end

	// The read side never gives back more slots than the FIFO has.
	// This holds only if the not-empty lookahead matches the RAM traffic.
	a_cap_max: assert property (@(posedge clk) disable iff (rst)
		capacity <= FIFO_WORDS)
		else $error("FIFO capacity above its size");

	// The space lookahead must stop a write before the last slot is gone.
	a_no_wr_full: assert property (@(posedge clk) disable iff (rst)
		wr_acc |-> (capacity != '0))
		else $error("FIFO write accepted while full");

endmodule

// File: nobl_if.sv
// Fixed read latency of four cycles from request; CE1n tied low and no sleep, burst or byte writes.
`timescale 1ns/1ns

module nobl_if
	import nobl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  ram_req_t  req,
	input  word_t     ram_d_pi,
	output word_t     ram_d_po,
	output logic      ram_d_poe,
	output ram_addr_t ram_a,
	output logic      ram_wen,
	output logic      ram_cenn,
	output logic      ram_ldn,
	output logic      ram_oen,
	output logic      ram_ce1n,
	output word_t     read_data,
	output logic      data_avail
);

	// Timing of one request issued in cycle N.
	// The address and control lows are on the pins in N+1.
	// The RAM samples them on the edge that starts N+2.
	// Write data has to be on the bus two cycles after the address, in N+3.
	// Read data is driven by the RAM in N+3 and held here in N+4.

	// Write data on its way to the data phase.
	word_t wr_data_d1;
	word_t wr_data_d2;

	// Marks the cycles whose delayed write data is real.
	logic wr_vld_d1;
	logic wr_vld_d2;

	// Read valid shift.
	// Bit 0 matches the address cycle on the pins, bit 2 the RAM data cycle.
	logic [2:0] rd_vld;

	// Only one chip is used, so the second chip enable stays asserted.
	assign ram_ce1n = 1'b0;

	// Control pins and valid bits.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ram_cenn   <= 1'b1;
			ram_ldn    <= 1'b1;
			ram_wen    <= 1'b1;
			ram_oen    <= 1'b0;
			ram_d_poe  <= 1'b0;
			wr_vld_d1  <= 1'b0;
			wr_vld_d2  <= 1'b0;
			rd_vld     <= '0;
			data_avail <= 1'b0;
		end
		else
		begin
			// Every operation is a fresh load of the address.
			ram_cenn <= !req.en;
			ram_ldn  <= !req.en;
			ram_wen  <= !(req.en && req.we);

			// Write phase tracking.
			wr_vld_d1 <= req.en && req.we;
			wr_vld_d2 <= wr_vld_d1;

			// The FPGA drives the bus in the write data phase.
			// The RAM outputs are switched off in the same cycle so the two
			// never fight over the bus.
			ram_d_poe <= wr_vld_d2;
			ram_oen   <= wr_vld_d2;

			// Read phase tracking.
			rd_vld <= {rd_vld[1:0], req.en && !req.we};

			// One pulse per read, in the cycle the word shows on read_data.
			data_avail <= rd_vld[2];
		end
	end

	// Address and data paths.
	// These carry no meaning unless the matching valid bit is set.
	always_ff @(posedge clk)
	begin
		ram_a      <= req.addr;
		wr_data_d1 <= req.wdata;
		wr_data_d2 <= wr_data_d1;
		ram_d_po   <= wr_data_d2;

		// Hold the last word until the next read returns.
		if (rd_vld[2])
		begin
			read_data <= ram_d_pi;
		end
	end

	// The FPGA drives the bus only with the RAM outputs off.
	// The write data phase must also never land in a cycle where the RAM returns read data.
	a_no_contention: assert property (@(posedge clk) disable iff (rst)
		ram_d_poe |-> (ram_oen && !rd_vld[2]))
		else $error("RAM data bus driven while RAM outputs enabled");

endmodule

// File: nobl_fifo.sv
// The reader must keep room for six returning words; FIFO_DEPTH must not exceed the RAM ADDR_W.
`timescale 1ns/1ns

module nobl_fifo
	import nobl_pkg::*;
#(
	// Pointer width.
	// The FIFO holds 2**(FIFO_DEPTH-1) words.
	parameter int FIFO_DEPTH = 19
)
(
	input  logic      clk,
	input  logic      rst,

	// RAM pins.
	input  word_t     ram_d_pi,
	output word_t     ram_d_po,
	output logic      ram_d_poe,
	output ram_addr_t ram_a,
	output logic      ram_wen,
	output logic      ram_cenn,
	output logic      ram_ldn,
	output logic      ram_oen,
	output logic      ram_ce1n,

	// User write side.
	input  word_t     write_data,
	input  logic      write_strobe,
	output logic      space_avail,

	// User read side.
	// Each accepted read returns one word with a data_avail pulse.
	output word_t     read_data,
	input  logic      read_strobe,
	output logic      data_avail
);

	// One RAM operation per cycle from the controller to the pins.
	ram_req_t req;

	// Pointers, capacity and the flags.
	nobl_fifo_ctrl #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_ctrl (
		.clk         (clk),
		.rst         (rst),
		.write_data  (write_data),
		.write_strobe(write_strobe),
		.read_strobe (read_strobe),
		.space_avail (space_avail),
		.req         (req)
	);

	// Pin sequencing and read data return.
	nobl_if i_if (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.ram_d_pi  (ram_d_pi),
		.ram_d_po  (ram_d_po),
		.ram_d_poe (ram_d_poe),
		.ram_a     (ram_a),
		.ram_wen   (ram_wen),
		.ram_cenn  (ram_cenn),
		.ram_ldn   (ram_ldn),
		.ram_oen   (ram_oen),
		.ram_ce1n  (ram_ce1n),
		.read_data (read_data),
		.data_avail(data_avail)
	);

endmodule

// File: tb_nobl_sram.sv
// Behavioral single-chip ZBT/NoBL model; only the low address bits that fit WORDS are decoded.
`timescale 1ns/1ns

module tb_nobl_sram
	import nobl_pkg::*;
#(
	// Number of words modelled.
	// Must be a power of two.
	parameter int WORDS = 256
)
(
	input  logic      clk,
	input  ram_addr_t a,
	input  logic      wen,
	input  logic      cenn,
	input  logic      ldn,
	input  logic      oen,
	input  logic      ce1n,
	input  word_t     d_in,
	input  logic      d_in_en,
	output word_t     d_out,
	output logic      phase_err
);

	localparam int AW = $clog2(WORDS);

	word_t mem [WORDS];

	// Command sampled on the last edge, and the one before it.
	logic          s1_vld;
	logic          s1_we;
	logic [AW-1:0] s1_addr;
	logic          s2_vld;
	logic          s2_we;
	logic [AW-1:0] s2_addr;

	// Read data register and the cycle in which the part drives it.
	word_t rd_q;
	logic  rd_drv;

	// Every word starts with a value tied to its full address.
	// A read of a never written word is then easy to spot in a mismatch.
	initial
	begin
		for (int i = 0; i < WORDS; i++)
		begin
			mem[i] = (word_t'(i) * word_t'(18'h000b3)) ^ word_t'(18'h2c35a);
		end
	end

	always @(posedge clk)
	begin
		// Address and controls are taken on every edge where the chip is selected.
		s1_vld  <= !cenn && !ldn && !ce1n;
		s1_we   <= !wen;
		s1_addr <= a[AW-1:0];
		s2_vld  <= s1_vld;
		s2_we   <= s1_we;
		s2_addr <= s1_addr;

		// Reads come out one edge after the address is taken.
		rd_drv <= s1_vld && !s1_we;
		rd_q   <= mem[s1_addr];

		// Writes take their data two edges after the address.
		if (s2_vld && s2_we)
		begin
			mem[s2_addr] <= d_in;
		end

		// Flags a write phase with an undriven bus, or read data while outputs are off.
		// A bus driven by the FPGA while the part's outputs are on is flagged too.
		phase_err <= (s2_vld && s2_we && !d_in_en) || (rd_drv && oen) ||
			(d_in_en && !oen);
	end

	// The part only drives the bus in its read data cycle with outputs enabled.
	assign d_out = (rd_drv && !oen) ? rd_q : 'x;

endmodule

// File: tb_nobl_fifo.sv
// Runs with FIFO_DEPTH 5 (16 entries) against a 256-word SRAM model; row checks assume that size.
`timescale 1ns/1ns

module tb_nobl_fifo
	import nobl_pkg::*;
();

	localparam int DEPTH_BITS = 5;
	localparam int FIFO_WORDS = 16;
	localparam int CLK_NS = 8;
	localparam int NUM_ROWS = 7;

	// Stimulus table.
	// Densities are in percent; a level of -1 means no level check at the row's end.
	string row_name [NUM_ROWS] = '{"fill", "drain", "prefill", "collide",
		"mixed_a", "mixed_b", "final_drain"};
	localparam int ROW_CYCLES [NUM_ROWS] = '{40, 40, 6, 12, 250, 200, 80};
	localparam int ROW_WR [NUM_ROWS] = '{100, 0, 100, 100, 60, 45, 0};
	localparam int ROW_RD [NUM_ROWS] = '{0, 100, 0, 100, 50, 65, 100};
	localparam int ROW_LEVEL [NUM_ROWS] = '{16, 0, 6, -1, -1, -1, 0};

	logic      clk = 1'b0;
	logic      rst;
	word_t     ram_d_pi;
	word_t     ram_d_po;
	logic      ram_d_poe;
	ram_addr_t ram_a;
	logic      ram_wen;
	logic      ram_cenn;
	logic      ram_ldn;
	logic      ram_oen;
	logic      ram_ce1n;
	word_t     write_data;
	logic      write_strobe;
	logic      read_strobe;
	logic      space_avail;
	word_t     read_data;
	logic      data_avail;
	logic      phase_err;

	// Words accepted by the FIFO and not yet returned, oldest first.
	word_t ref_q [$];

	integer seed = 5035;
	int     errors = 0;
	int     checks = 0;
	int     row_errs;
	int     row_writes;
	int     row_reads;
	logic   expect_sa_low = 1'b0;

	always #(CLK_NS / 2) clk = ~clk;

	nobl_fifo #(
		.FIFO_DEPTH(DEPTH_BITS)
	) i_dut (
		.clk         (clk),
		.rst         (rst),
		.ram_d_pi    (ram_d_pi),
		.ram_d_po    (ram_d_po),
		.ram_d_poe   (ram_d_poe),
		.ram_a       (ram_a),
		.ram_wen     (ram_wen),
		.ram_cenn    (ram_cenn),
		.ram_ldn     (ram_ldn),
		.ram_oen     (ram_oen),
		.ram_ce1n    (ram_ce1n),
		.write_data  (write_data),
		.write_strobe(write_strobe),
		.space_avail (space_avail),
		.read_data   (read_data),
		.read_strobe (read_strobe),
		.data_avail  (data_avail)
	);

	tb_nobl_sram #(
		.WORDS(256)
	) i_sram (
		.clk      (clk),
		.a        (ram_a),
		.wen      (ram_wen),
		.cenn     (ram_cenn),
		.ldn      (ram_ldn),
		.oen      (ram_oen),
		.ce1n     (ram_ce1n),
		.d_in     (ram_d_po),
		.d_in_en  (ram_d_poe),
		.d_out    (ram_d_pi),
		.phase_err(phase_err)
	);

	task automatic note_error();
		errors++;
		row_errs++;
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp)
		begin
			note_error();
			$display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			note_error();
			$display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp)
		begin
			note_error();
			$display("FAIL %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// True with the given chance in percent.
	function automatic logic pct_hit(input int pct);
		int r;
		r = $random(seed) % 100;
		if (r < 0)
		begin
			r = -r;
		end
		return r < pct;
	endfunction

	// One clock cycle: check what the last edge produced, then drive the next inputs.
	task automatic run_cycle(input int wr_pct, input int rd_pct);
		word_t exp;
		logic  wr_taken;
		@(negedge clk);
		check_flag("sram_phase_err", phase_err, 1'b0);
		if (expect_sa_low)
		begin
			check_flag("space_avail", space_avail, 1'b0);
		end
		if (data_avail)
		begin
			if (ref_q.size() == 0)
			begin
				note_error();
				$display("ERROR: data_avail pulsed with no read outstanding at %0t", $time);
			end
			else
			begin
				exp = ref_q.pop_front();
				check_word("read_data", read_data, exp);
				row_reads++;
			end
		end
		write_strobe = pct_hit(wr_pct);
		read_strobe  = pct_hit(rd_pct);
		write_data   = word_t'($random(seed));
		// Acceptance is judged from the ports, as a user would see it.
		wr_taken = write_strobe && space_avail;
		if (wr_taken)
		begin
			ref_q.push_back(write_data);
			row_writes++;
		end
		// Space must drop after the last free slot is taken, or after a collision.
		expect_sa_low = wr_taken && (((wr_pct == 100) && (rd_pct == 100) && read_strobe) ||
			((rd_pct == 0) && (ref_q.size() == FIFO_WORDS)));
	endtask

	task automatic apply_row(input int idx);
		row_errs   = 0;
		row_writes = 0;
		row_reads  = 0;
		for (int c = 0; c < ROW_CYCLES[idx]; c++)
		begin
			run_cycle(ROW_WR[idx], ROW_RD[idx]);
		end
		if (ROW_LEVEL[idx] >= 0)
		begin
			check_count({row_name[idx], "_level"}, ref_q.size(), ROW_LEVEL[idx]);
		end
		$display("%-12s cycles %0d writes %0d reads %0d errors %0d", row_name[idx],
			ROW_CYCLES[idx], row_writes, row_reads, row_errs);
	endtask

	// Ends a run that no longer makes progress.
	initial
	begin
		int total;
		total = 0;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			total += ROW_CYCLES[i];
		end
		#((total + 64) * CLK_NS);
		$display("ERROR: timeout, the table did not finish within %0d cycles", total + 64);
		$display("TB FAILED");
		$finish;
	end

	initial
	begin
		rst          = 1'b1;
		write_strobe = 1'b0;
		read_strobe  = 1'b0;
		write_data   = '0;
		row_errs     = 0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		// Outputs still show their reset values in the first cycle.
		@(negedge clk);
		check_flag("data_avail", data_avail, 1'b0);
		check_flag("ram_cenn", ram_cenn, 1'b1);
		check_flag("ram_wen", ram_wen, 1'b1);
		check_flag("ram_ldn", ram_ldn, 1'b1);
		check_flag("ram_d_poe", ram_d_poe, 1'b0);
		@(negedge clk);
		check_flag("space_avail", space_avail, 1'b1);
		$display("%-12s errors %0d", "reset", row_errs);
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			apply_row(i);
		end
		$display("checks %0d errors %0d words left %0d", checks, errors, ref_q.size());
		if (errors == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
nobl_pkg.sv
nobl_fifo_ctrl.sv
nobl_if.sv
nobl_fifo.sv
tb_nobl_sram.sv
tb_nobl_fifo.sv

// File: Makefile
# Verilator build and run of the NoBL FIFO testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_nobl_fifo
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TB FAILED
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

# Builds the model, runs it, and decides the result from the log.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation gave no result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
